//--- csr_regfile.f
+incdir+.
csr_pkg.sv
csr_access.sv
csr_trap_regs.sv
csr_counters.sv
csr_regfile.sv
tb_csr_regfile.sv

//--- Makefile
# Verilator build and run for the CSR file testbench
# any variable can be overridden, e.g. make run LOG=other.log

VERILATOR ?= verilator
TOP       ?= tb_csr_regfile
FILELIST  ?= csr_regfile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_MSG  ?= Result: FAILED
PASS_MSG  ?= Result: PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "simulation ended without a result"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tb_csr_regfile.sv
/*
 * directed testbench for the machine-mode CSR file
 * reset values, access ops, legalisation, trap round trip, counters
 */
`timescale 1ns/1ps
`include "csr_defines.svh"

module tb_csr_regfile;

  localparam int CLK_PERIOD = 20;
  localparam int POLL_LIMIT = 50;       // cycles per bounded wait
  localparam int WATCHDOG   = 200000;   // ns for the whole run

  logic               clk;
  logic               rst_n;
  csr_pkg::csr_addr_e csr_addr;
  csr_pkg::csr_op_e   csr_op;
  logic [31:0]        csr_wdata;
  logic [31:0]        csr_rdata;
  logic [31:0]        hart_id, mip, mtvec_boot;
  logic               mtvec_init;
  logic [31:0]        pc_if, pc_id, pc_ex;
  logic               save_cause, save_if, save_id, save_ex, restore_mret;
  logic [5:0]         cause;
  logic               minstret_evt;
  logic [31:0]        mie_bypass, mepc;
  logic [23:0]        mtvec_base;
  logic [1:0]         mtvec_mode;
  logic               m_irq_enable;
  integer             seed;

  csr_regfile UUT (
    .clk (clk), .rst_n (rst_n),
    .csr_addr_i (csr_addr), .csr_op_i (csr_op),
    .csr_wdata_i (csr_wdata), .csr_rdata_o (csr_rdata),
    .hart_id_i (hart_id), .mip_i (mip),
    .mtvec_addr_i (mtvec_boot), .csr_mtvec_init_i (mtvec_init),
    .pc_if_i (pc_if), .pc_id_i (pc_id), .pc_ex_i (pc_ex),
    .csr_save_cause_i (save_cause), .csr_save_if_i (save_if),
    .csr_save_id_i (save_id), .csr_save_ex_i (save_ex),
    .csr_restore_mret_i (restore_mret), .csr_cause_i (cause),
    .mhpmevent_minstret_i (minstret_evt),
    .mie_bypass_o (mie_bypass), .mepc_o (mepc),
    .mtvec_addr_o (mtvec_base), .mtvec_mode_o (mtvec_mode),
    .m_irq_enable_o (m_irq_enable)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD/2) clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////////////////////////

  task automatic fail_stop(input string what);
    $display("%s", what);
    $display("Result: FAILED");
    $fatal(1, "stopping at first failure");
  endtask

  task automatic check_eq(input string name, input logic [31:0] act,
                          input logic [31:0] exp);
    if (act !== exp) begin
      fail_stop($sformatf("[ERROR] t=%0t %s: got 0x%08h, expected 0x%08h",
                          $time, name, act, exp));
    end
  endtask

  // one op driven on the falling edge and written at the next rising edge
  task automatic apply_op(input csr_pkg::csr_addr_e addr, input csr_pkg::csr_op_e op,
                          input logic [31:0] data);
    @(negedge clk);
    csr_addr  = addr;
    csr_op    = op;
    csr_wdata = data;
    @(negedge clk);
    csr_op    = csr_pkg::CSR_OP_READ;  // back to idle
  endtask

  task automatic csr_write(input csr_pkg::csr_addr_e addr, input logic [31:0] data);
    apply_op(addr, csr_pkg::CSR_OP_WRITE, data);
  endtask

  task automatic csr_set(input csr_pkg::csr_addr_e addr, input logic [31:0] data);
    apply_op(addr, csr_pkg::CSR_OP_SET, data);
  endtask

  task automatic csr_clear(input csr_pkg::csr_addr_e addr, input logic [31:0] data);
    apply_op(addr, csr_pkg::CSR_OP_CLEAR, data);
  endtask

  // combinational read sampled mid low phase
  task automatic csr_read(input csr_pkg::csr_addr_e addr, output logic [31:0] data);
    @(negedge clk);
    csr_addr = addr;
    csr_op   = csr_pkg::CSR_OP_READ;
    #(CLK_PERIOD/4);
    data = csr_rdata;
  endtask

  task automatic read_check(input csr_pkg::csr_addr_e addr, input string name,
                            input logic [31:0] exp);
    logic [31:0] val;
    csr_read(addr, val);
    check_eq(name, val, exp);
  endtask

  task automatic idle_cycles(input int n);
    for (int i = 0; i < n; i++) @(negedge clk);
  endtask

  // sel 0 = if, 1 = id, 2 = ex
  task automatic trap_save(input int sel, input logic [5:0] code);
    @(negedge clk);
    save_cause = 1'b1;
    save_if    = (sel == 0);
    save_id    = (sel == 1);
    save_ex    = (sel == 2);
    cause      = code;
    @(negedge clk);
    save_cause = 1'b0;
    save_if    = 1'b0;
    save_id    = 1'b0;
    save_ex    = 1'b0;
  endtask

  task automatic mret();
    @(negedge clk);
    restore_mret = 1'b1;
    @(negedge clk);
    restore_mret = 1'b0;
  endtask

  task automatic wait_mcycle_moves();
    logic [31:0] val;
    int          polls;
    polls = 0;
    val   = '0;
    while (val == 32'd0 && polls < POLL_LIMIT) begin
      csr_read(csr_pkg::CSR_MCYCLE, val);
      polls++;
    end
    if (val == 32'd0) fail_stop("timeout: mcycle never started counting");
  endtask

  //////////////////////////////////////////////////////////////////////
  // directed tests
  //////////////////////////////////////////////////////////////////////

  task automatic test_reset();
    read_check(csr_pkg::CSR_MSTATUS, "mstatus", 32'h0000_1800);
    read_check(csr_pkg::CSR_MISA, "misa", `CSR_MISA_VALUE);
    read_check(csr_pkg::CSR_MHARTID, "mhartid", hart_id);
    read_check(csr_pkg::CSR_MTVEC, "mtvec", 32'h0000_0001);
    read_check(csr_pkg::CSR_MCOUNTINHIBIT, "mcountinhibit", 32'h0000_0005);
    read_check(csr_pkg::CSR_MCYCLE, "mcycle", 32'd0);   // stopped since reset
    read_check(csr_pkg::CSR_MINSTRET, "minstret", 32'd0);
    check_eq("m_irq_enable_o", {31'd0, m_irq_enable}, 32'd0);
  endtask

  task automatic test_access();
    logic [31:0] d, s, c, m, exp;
    d = $random(seed);
    s = $random(seed);
    c = $random(seed);
    m = $random(seed);
    csr_write(csr_pkg::CSR_MSCRATCH, d);
    read_check(csr_pkg::CSR_MSCRATCH, "mscratch write", d);
    csr_set(csr_pkg::CSR_MSCRATCH, s);
    exp = d | s;
    read_check(csr_pkg::CSR_MSCRATCH, "mscratch set", exp);
    csr_clear(csr_pkg::CSR_MSCRATCH, c);
    exp = exp & ~c;
    read_check(csr_pkg::CSR_MSCRATCH, "mscratch clear", exp);
    apply_op(csr_pkg::CSR_MSCRATCH, csr_pkg::CSR_OP_READ, ~exp);  // no write
    read_check(csr_pkg::CSR_MSCRATCH, "mscratch read", exp);
    // mie bypass seen in the write cycle itself
    @(negedge clk);
    csr_addr  = csr_pkg::CSR_MIE;
    csr_op    = csr_pkg::CSR_OP_WRITE;
    csr_wdata = m;
    #(CLK_PERIOD/4);
    check_eq("mie_bypass_o", mie_bypass, m & `CSR_IRQ_MASK);
    @(negedge clk);
    csr_op = csr_pkg::CSR_OP_READ;
    read_check(csr_pkg::CSR_MIE, "mie", m & `CSR_IRQ_MASK);
  endtask

  task automatic test_legalise();
    logic [31:0] d, r, boot;
    d = $random(seed);
    csr_write(csr_pkg::CSR_MEPC, d);
    read_check(csr_pkg::CSR_MEPC, "mepc", d & 32'hFFFF_FFFE);
    d = $random(seed);
    csr_write(csr_pkg::CSR_MCAUSE, d);
    read_check(csr_pkg::CSR_MCAUSE, "mcause", d & 32'h8000_001F);
    d = $random(seed);
    csr_write(csr_pkg::CSR_MSTATUS, d);
    csr_read(csr_pkg::CSR_MSTATUS, r);
    check_eq("mstatus", r, (d & 32'h0000_0088) | 32'h0000_1800);
    d = $random(seed);
    csr_write(csr_pkg::CSR_MTVEC, d);
    read_check(csr_pkg::CSR_MTVEC, "mtvec", d & 32'hFFFF_FF01);
    check_eq("mtvec_addr_o", {8'd0, mtvec_base}, {8'd0, d[31:8]});
    check_eq("mtvec_mode_o", {30'd0, mtvec_mode}, {31'd0, d[0]});
    // boot address load keeps the mode bit
    boot = $random(seed);
    @(negedge clk);
    mtvec_boot = boot;
    mtvec_init = 1'b1;
    @(negedge clk);
    mtvec_init = 1'b0;
    read_check(csr_pkg::CSR_MTVEC, "mtvec init", {boot[31:8], 7'd0, d[0]});
  endtask

  task automatic test_trap();
    logic [31:0] pc, sw;
    logic [5:0]  code;
    @(negedge clk);
    pc    = $random(seed) & 32'hFFFF_FFFE;
    pc_if = $random(seed);
    pc_id = $random(seed);
    pc_ex = pc;
    code  = 6'b10_1011;  // external irq
    csr_write(csr_pkg::CSR_MSTATUS, 32'h0000_0008);
    check_eq("m_irq_enable_o", {31'd0, m_irq_enable}, 32'd1);
    trap_save(2, code);
    read_check(csr_pkg::CSR_MEPC, "mepc trap", pc);
    check_eq("mepc_o", mepc, pc);
    read_check(csr_pkg::CSR_MCAUSE, "mcause trap", {code[5], 26'd0, code[4:0]});
    read_check(csr_pkg::CSR_MSTATUS, "mstatus trap", 32'h0000_1880);  // mpie=1 mie=0
    check_eq("m_irq_enable_o", {31'd0, m_irq_enable}, 32'd0);
    mret();
    read_check(csr_pkg::CSR_MSTATUS, "mstatus mret", 32'h0000_1888);
    check_eq("m_irq_enable_o", {31'd0, m_irq_enable}, 32'd1);
    // software mepc write collides with a save
    sw = $random(seed);
    @(negedge clk);
    pc_id      = $random(seed) & 32'hFFFF_FFFE;
    csr_addr   = csr_pkg::CSR_MEPC;
    csr_op     = csr_pkg::CSR_OP_WRITE;
    csr_wdata  = sw;
    save_cause = 1'b1;
    save_id    = 1'b1;
    cause      = 6'd2;
    @(negedge clk);
    csr_op     = csr_pkg::CSR_OP_READ;
    save_cause = 1'b0;
    save_id    = 1'b0;
    read_check(csr_pkg::CSR_MEPC, "mepc collision", pc_id);
    read_check(csr_pkg::CSR_MCAUSE, "mcause collision", 32'd2);
  endtask

  task automatic test_counters();
    logic [31:0] a, b, rnd, h, l;
    int          n, high_cycles;
    csr_write(csr_pkg::CSR_MCOUNTINHIBIT, 32'hFFFF_FFFF);
    read_check(csr_pkg::CSR_MCOUNTINHIBIT, "mcountinhibit", 32'h0000_0005);
    csr_write(csr_pkg::CSR_MCOUNTINHIBIT, 32'd0);
    read_check(csr_pkg::CSR_MCOUNTINHIBIT, "mcountinhibit", 32'd0);
    wait_mcycle_moves();
    // mcycle delta over n cycles
    rnd = $random(seed);
    n   = 4 + int'(rnd[2:0]);
    csr_read(csr_pkg::CSR_MCYCLE, a);
    idle_cycles(n - 1);                 // csr_read adds the last one
    csr_read(csr_pkg::CSR_MCYCLE, b);
    check_eq("mcycle delta", b - a, 32'(n));
    // minstret counts cycles with the retire event high
    high_cycles = 0;
    csr_read(csr_pkg::CSR_MINSTRET, a);
    for (int i = 0; i < 12; i++) begin
      @(negedge clk);
      rnd          = $random(seed);
      minstret_evt = rnd[0];
      if (rnd[0]) high_cycles++;
    end
    @(negedge clk);
    minstret_evt = 1'b0;
    csr_read(csr_pkg::CSR_MINSTRET, b);
    check_eq("minstret delta", b - a, 32'(high_cycles));
    // half-word writes then counting resumes from them
    h = $random(seed);
    l = $random(seed) & 32'h7FFF_FFFF;  // no carry into high
    csr_write(csr_pkg::CSR_MCYCLEH, h);
    csr_write(csr_pkg::CSR_MCYCLE, l);
    read_check(csr_pkg::CSR_MCYCLE, "mcycle lo", l + 32'd1);
    read_check(csr_pkg::CSR_MCYCLEH, "mcycle hi", h);
    // inhibit freezes both
    csr_write(csr_pkg::CSR_MCOUNTINHIBIT, 32'h0000_0005);
    csr_read(csr_pkg::CSR_MCYCLE, a);
    csr_read(csr_pkg::CSR_MINSTRET, h);
    @(negedge clk);
    minstret_evt = 1'b1;
    idle_cycles(6);
    minstret_evt = 1'b0;
    read_check(csr_pkg::CSR_MCYCLE, "mcycle frozen", a);
    read_check(csr_pkg::CSR_MINSTRET, "minstret frozen", h);
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    seed         = 55;
    rst_n        = 1'b0;
    csr_addr     = csr_pkg::CSR_MSTATUS;
    csr_op       = csr_pkg::CSR_OP_READ;
    csr_wdata    = '0;
    hart_id      = $random(seed);
    mip          = '0;
    mtvec_boot   = '0;
    mtvec_init   = 1'b0;
    pc_if        = '0;
    pc_id        = '0;
    pc_ex        = '0;
    save_cause   = 1'b0;
    save_if      = 1'b0;
    save_id      = 1'b0;
    save_ex      = 1'b0;
    restore_mret = 1'b0;
    cause        = '0;
    minstret_evt = 1'b0;
    for (int i = 0; i < 8; i++) @(negedge clk);  // reset for 8 cycles
    rst_n = 1'b1;
    test_reset();
    test_access();
    test_legalise();
    test_trap();
    test_counters();
    $display("Result: PASSED");
    $finish;
  end

  // hang guard
  initial begin
    #(WATCHDOG);
    fail_stop("timeout: run did not finish in time");
  end

endmodule

//--- csr_regfile.sv
/*
 * machine-mode CSR file top level
 * access logic, trap registers and performance counters
 */
`timescale 1ns/1ps
`include "csr_defines.svh"

module csr_regfile (
  input  logic                 clk,
  input  logic                 rst_n,
  // software access, read is combinational
  input  csr_pkg::csr_addr_e   csr_addr_i,
  input  csr_pkg::csr_op_e     csr_op_i,
  input  logic [`CSR_XLEN-1:0] csr_wdata_i,
  output logic [`CSR_XLEN-1:0] csr_rdata_o,
  // core state
  input  logic [`CSR_XLEN-1:0] hart_id_i,
  input  logic [`CSR_XLEN-1:0] mip_i,
  input  logic [`CSR_XLEN-1:0] mtvec_addr_i,
  input  logic                 csr_mtvec_init_i,
  input  logic [`CSR_XLEN-1:0] pc_if_i,
  input  logic [`CSR_XLEN-1:0] pc_id_i,
  input  logic [`CSR_XLEN-1:0] pc_ex_i,
  // exception controller pulses
  input  logic                 csr_save_cause_i,
  input  logic                 csr_save_if_i,
  input  logic                 csr_save_id_i,
  input  logic                 csr_save_ex_i,
  input  logic                 csr_restore_mret_i,
  input  logic [5:0]           csr_cause_i,
  input  logic                 mhpmevent_minstret_i,
  // to the core
  output logic [`CSR_XLEN-1:0] mie_bypass_o,
  output logic [`CSR_XLEN-1:0] mepc_o,
  output logic [23:0]          mtvec_addr_o,
  output logic [1:0]           mtvec_mode_o,
  output logic                 m_irq_enable_o
);

  logic [`CSR_XLEN-1:0] trap_rdata;  // per-block read data
  logic [`CSR_XLEN-1:0] cnt_rdata;
  logic [`CSR_XLEN-1:0] wr_data;     // after read-modify-write
  logic                 wr_en;

  csr_access u_access (
    .csr_op_i     (csr_op_i),
    .csr_wdata_i  (csr_wdata_i),
    .trap_rdata_i (trap_rdata),
    .cnt_rdata_i  (cnt_rdata),
    .csr_rdata_o  (csr_rdata_o),
    .wr_data_o    (wr_data),
    .wr_en_o      (wr_en)
  );

  csr_trap_regs u_trap (
    .clk                (clk),
    .rst_n              (rst_n),
    .csr_addr_i         (csr_addr_i),
    .wr_data_i          (wr_data),
    .wr_en_i            (wr_en),
    .csr_op_i           (csr_op_i),
    .csr_wdata_i        (csr_wdata_i),
    .hart_id_i          (hart_id_i),
    .mip_i              (mip_i),
    .mtvec_addr_i       (mtvec_addr_i),
    .pc_if_i            (pc_if_i),
    .pc_id_i            (pc_id_i),
    .pc_ex_i            (pc_ex_i),
    .csr_mtvec_init_i   (csr_mtvec_init_i),
    .csr_save_cause_i   (csr_save_cause_i),
    .csr_save_if_i      (csr_save_if_i),
    .csr_save_id_i      (csr_save_id_i),
    .csr_save_ex_i      (csr_save_ex_i),
    .csr_restore_mret_i (csr_restore_mret_i),
    .csr_cause_i        (csr_cause_i),
    .rdata_o            (trap_rdata),
    .mie_bypass_o       (mie_bypass_o),
    .mepc_o             (mepc_o),
    .mtvec_addr_o       (mtvec_addr_o),
    .mtvec_mode_o       (mtvec_mode_o),
    .m_irq_enable_o     (m_irq_enable_o)
  );

  csr_counters u_counters (
    .clk                  (clk),
    .rst_n                (rst_n),
    .csr_addr_i           (csr_addr_i),
    .wr_data_i            (wr_data),
    .wr_en_i              (wr_en),
    .mhpmevent_minstret_i (mhpmevent_minstret_i),
    .rdata_o              (cnt_rdata)
  );

endmodule

//--- csr_counters.sv
/*
 * machine performance counters
 * 64-bit mcycle and minstret with half-word writes,
 * mcountinhibit with only bits 0 and 2 implemented
 */
`timescale 1ns/1ps
`include "csr_defines.svh"

module csr_counters (
  input  logic                 clk,
  input  logic                 rst_n,
  input  csr_pkg::csr_addr_e   csr_addr_i,
  input  logic [`CSR_XLEN-1:0] wr_data_i,
  input  logic                 wr_en_i,
  input  logic                 mhpmevent_minstret_i,  // one per retired instr
  output logic [`CSR_XLEN-1:0] rdata_o
);

  logic [`CSR_CNT_WIDTH-1:0] mcycle_q, mcycle_n;
  logic [`CSR_CNT_WIDTH-1:0] minstret_q, minstret_n;
  logic                      inhibit_cy_q;  // mcountinhibit[0]
  logic                      inhibit_ir_q;  // mcountinhibit[2]

  logic mcycle_wr_lo, mcycle_wr_hi;
  logic minstret_wr_lo, minstret_wr_hi;
  logic inhibit_wr;
  logic mcycle_inc, minstret_inc;

  //////////////////////////////////////////////////////////////////////
  // write decode
  //////////////////////////////////////////////////////////////////////

  assign mcycle_wr_lo   = wr_en_i && (csr_addr_i == csr_pkg::CSR_MCYCLE);
  assign mcycle_wr_hi   = wr_en_i && (csr_addr_i == csr_pkg::CSR_MCYCLEH);
  assign minstret_wr_lo = wr_en_i && (csr_addr_i == csr_pkg::CSR_MINSTRET);
  assign minstret_wr_hi = wr_en_i && (csr_addr_i == csr_pkg::CSR_MINSTRETH);
  assign inhibit_wr     = wr_en_i && (csr_addr_i == csr_pkg::CSR_MCOUNTINHIBIT);

  assign mcycle_inc   = !inhibit_cy_q;                          // every cycle
  assign minstret_inc = !inhibit_ir_q && mhpmevent_minstret_i;  // per retire

  // half-word write replaces the increment for that cycle
  function automatic logic [`CSR_CNT_WIDTH-1:0] cnt_next(
    input logic [`CSR_CNT_WIDTH-1:0] q,
    input logic                      wr_lo,
    input logic                      wr_hi,
    input logic                      inc,
    input logic [`CSR_XLEN-1:0]      wdata
  );
    logic [`CSR_CNT_WIDTH-1:0] n;
    n = q;
    if (wr_lo) begin
      n[`CSR_XLEN-1:0] = wdata;
    end else if (wr_hi) begin
      n[`CSR_CNT_WIDTH-1:`CSR_XLEN] = wdata;
    end else if (inc) begin
      n = q + `CSR_CNT_WIDTH'(1);
    end
    return n;
  endfunction

  assign mcycle_n   = cnt_next(mcycle_q, mcycle_wr_lo, mcycle_wr_hi, mcycle_inc, wr_data_i);
  assign minstret_n = cnt_next(minstret_q, minstret_wr_lo, minstret_wr_hi,
                               minstret_inc, wr_data_i);

  //////////////////////////////////////////////////////////////////////
  // registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mcycle_q     <= '0;
      minstret_q   <= '0;
      inhibit_cy_q <= 1'b1;  // counters stopped out of reset
      inhibit_ir_q <= 1'b1;
    end else begin
      mcycle_q   <= mcycle_n;
      minstret_q <= minstret_n;
      if (inhibit_wr) begin
        inhibit_cy_q <= wr_data_i[0];
        inhibit_ir_q <= wr_data_i[2];
      end
    end
  end

  // read mux
  always_comb begin
    case (csr_addr_i)
      csr_pkg::CSR_MCYCLE:    rdata_o = mcycle_q[`CSR_XLEN-1:0];
      csr_pkg::CSR_MCYCLEH:   rdata_o = mcycle_q[`CSR_CNT_WIDTH-1:`CSR_XLEN];
      csr_pkg::CSR_MINSTRET:  rdata_o = minstret_q[`CSR_XLEN-1:0];
      csr_pkg::CSR_MINSTRETH: rdata_o = minstret_q[`CSR_CNT_WIDTH-1:`CSR_XLEN];
      csr_pkg::CSR_MCOUNTINHIBIT: begin
        rdata_o    = '0;              // unimplemented bits read 0
        rdata_o[0] = inhibit_cy_q;
        rdata_o[2] = inhibit_ir_q;
      end
      default: rdata_o = '0;
    endcase
  end

  // inhibited and untouched counter holds its value
  a_mcycle_frozen: assert property (@(posedge clk) disable iff (!rst_n)
    (inhibit_cy_q && !mcycle_wr_lo && !mcycle_wr_hi) |=> $stable(mcycle_q));

  a_minstret_frozen: assert property (@(posedge clk) disable iff (!rst_n)
    (inhibit_ir_q && !minstret_wr_lo && !minstret_wr_hi) |=> $stable(minstret_q));

endmodule

//--- csr_trap_regs.sv
/*
 * machine trap registers
 * mstatus, mie, mtvec, mscratch, mepc, mcause with write legalisation,
 * trap save / mret sequencing, misa/mhartid/mip read and mie bypass
 */
`timescale 1ns/1ps
`include "csr_defines.svh"

module csr_trap_regs (
  input  logic                 clk,
  input  logic                 rst_n,
  // software access
  input  csr_pkg::csr_addr_e   csr_addr_i,
  input  logic [`CSR_XLEN-1:0] wr_data_i,
  input  logic                 wr_en_i,
  input  csr_pkg::csr_op_e     csr_op_i,     // raw op, for bypass only
  input  logic [`CSR_XLEN-1:0] csr_wdata_i,  // raw data, for bypass only
  // core state
  input  logic [`CSR_XLEN-1:0] hart_id_i,
  input  logic [`CSR_XLEN-1:0] mip_i,
  input  logic [`CSR_XLEN-1:0] mtvec_addr_i, // boot address
  input  logic [`CSR_XLEN-1:0] pc_if_i,
  input  logic [`CSR_XLEN-1:0] pc_id_i,
  input  logic [`CSR_XLEN-1:0] pc_ex_i,
  // exception controller
  input  logic                 csr_mtvec_init_i,
  input  logic                 csr_save_cause_i,
  input  logic                 csr_save_if_i,
  input  logic                 csr_save_id_i,
  input  logic                 csr_save_ex_i,
  input  logic                 csr_restore_mret_i,
  input  logic [5:0]           csr_cause_i,  // bit 5 flags an interrupt
  // outputs
  output logic [`CSR_XLEN-1:0] rdata_o,
  output logic [`CSR_XLEN-1:0] mie_bypass_o,
  output logic [`CSR_XLEN-1:0] mepc_o,
  output logic [23:0]          mtvec_addr_o,
  output logic [1:0]           mtvec_mode_o,
  output logic                 m_irq_enable_o
);

  logic [`CSR_XLEN-1:0] mstatus_q, mstatus_n;
  logic [`CSR_XLEN-1:0] mie_q, mie_n;
  logic [`CSR_XLEN-1:0] mtvec_q, mtvec_n;
  logic [`CSR_XLEN-1:0] mscratch_q, mscratch_n;
  logic [`CSR_XLEN-1:0] mepc_q, mepc_n;
  logic [`CSR_XLEN-1:0] mcause_q, mcause_n;
  logic [`CSR_XLEN-1:0] exception_pc;
  logic [`CSR_XLEN-1:0] mie_wdata;   // bypass copy of the op result
  logic                 mie_we;

  //////////////////////////////////////////////////////////////////////
  // mie bypass, lets the next instruction see a fresh mie
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    mie_wdata = csr_wdata_i;
    mie_we    = 1'b1;
    case (csr_op_i)
      csr_pkg::CSR_OP_WRITE: mie_wdata = csr_wdata_i;
      csr_pkg::CSR_OP_SET:   mie_wdata = csr_wdata_i | mie_q;
      csr_pkg::CSR_OP_CLEAR: mie_wdata = ~csr_wdata_i & mie_q;
      default:               mie_we    = 1'b0;
    endcase
  end

  assign mie_bypass_o = (csr_addr_i == csr_pkg::CSR_MIE && mie_we) ?
                        (mie_wdata & `CSR_IRQ_MASK) : mie_q;

  // pc of the instruction that trapped
  always_comb begin
    exception_pc = pc_id_i;
    if (csr_save_if_i)      exception_pc = pc_if_i;
    else if (csr_save_ex_i) exception_pc = pc_ex_i;
  end

  //////////////////////////////////////////////////////////////////////
  // next state, software writes first, then trap overrides
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    mstatus_n  = mstatus_q;
    mie_n      = mie_q;
    mscratch_n = mscratch_q;
    mepc_n     = mepc_q;
    mcause_n   = mcause_q;
    mtvec_n    = mtvec_q;
    if (csr_mtvec_init_i) begin
      mtvec_n[`CSR_XLEN-1:`CSR_MTVEC_BASE_LSB] = mtvec_addr_i[`CSR_XLEN-1:`CSR_MTVEC_BASE_LSB];
    end

    if (wr_en_i) begin
      case (csr_addr_i)
        csr_pkg::CSR_MSTATUS: begin
          mstatus_n = `CSR_MSTATUS_RESET;  // MPP stuck at machine
          mstatus_n[`CSR_MSTATUS_MIE_BIT]  = wr_data_i[`CSR_MSTATUS_MIE_BIT];
          mstatus_n[`CSR_MSTATUS_MPIE_BIT] = wr_data_i[`CSR_MSTATUS_MPIE_BIT];
        end
        csr_pkg::CSR_MIE:      mie_n = wr_data_i & `CSR_IRQ_MASK;
        csr_pkg::CSR_MTVEC: begin
          mtvec_n = '0;
          mtvec_n[`CSR_XLEN-1:`CSR_MTVEC_BASE_LSB] = wr_data_i[`CSR_XLEN-1:`CSR_MTVEC_BASE_LSB];
          mtvec_n[0] = wr_data_i[0];  // direct or vectored only
        end
        csr_pkg::CSR_MSCRATCH: mscratch_n = wr_data_i;
        csr_pkg::CSR_MEPC:     mepc_n = {wr_data_i[`CSR_XLEN-1:1], 1'b0};  // halfword aligned
        csr_pkg::CSR_MCAUSE: begin
          mcause_n = '0;
          mcause_n[`CSR_XLEN-1] = wr_data_i[`CSR_XLEN-1];
          mcause_n[`CSR_MCAUSE_CODE_W-1:0] = wr_data_i[`CSR_MCAUSE_CODE_W-1:0];
        end
        default: ;
      endcase
    end

    // exception controller wins over software
    if (csr_save_cause_i) begin
      mstatus_n = mstatus_q;
      mstatus_n[`CSR_MSTATUS_MPIE_BIT] = mstatus_q[`CSR_MSTATUS_MIE_BIT];
      mstatus_n[`CSR_MSTATUS_MIE_BIT]  = 1'b0;
      mepc_n   = exception_pc;
      mcause_n = '0;
      mcause_n[`CSR_XLEN-1] = csr_cause_i[`CSR_MCAUSE_CODE_W];
      mcause_n[`CSR_MCAUSE_CODE_W-1:0] = csr_cause_i[`CSR_MCAUSE_CODE_W-1:0];
    end else if (csr_restore_mret_i) begin
      mstatus_n = mstatus_q;
      mstatus_n[`CSR_MSTATUS_MIE_BIT]  = mstatus_q[`CSR_MSTATUS_MPIE_BIT];
      mstatus_n[`CSR_MSTATUS_MPIE_BIT] = 1'b1;
    end
  end

  // control registers
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mstatus_q <= `CSR_MSTATUS_RESET;
      mie_q     <= '0;
      mtvec_q   <= `CSR_MTVEC_RESET;
    end else begin
      mstatus_q <= mstatus_n;
      mie_q     <= mie_n;
      mtvec_q   <= mtvec_n;
    end
  end

  // payload, software sets before use
  always_ff @(posedge clk) begin
    mscratch_q <= mscratch_n;
    mepc_q     <= mepc_n;
    mcause_q   <= mcause_n;
  end

  //////////////////////////////////////////////////////////////////////
  // read mux, zero for addresses owned elsewhere
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    case (csr_addr_i)
      csr_pkg::CSR_MSTATUS:  rdata_o = mstatus_q;
      csr_pkg::CSR_MISA:     rdata_o = `CSR_MISA_VALUE;
      csr_pkg::CSR_MIE:      rdata_o = mie_q;
      csr_pkg::CSR_MTVEC:    rdata_o = mtvec_q;
      csr_pkg::CSR_MSCRATCH: rdata_o = mscratch_q;
      csr_pkg::CSR_MEPC:     rdata_o = mepc_q;
      csr_pkg::CSR_MCAUSE:   rdata_o = mcause_q;
      csr_pkg::CSR_MIP:      rdata_o = mip_i;
      csr_pkg::CSR_MHARTID:  rdata_o = hart_id_i;
      default:               rdata_o = '0;
    endcase
  end

  assign m_irq_enable_o = mstatus_q[`CSR_MSTATUS_MIE_BIT];
  assign mtvec_addr_o   = mtvec_q[`CSR_XLEN-1:`CSR_MTVEC_BASE_LSB];
  assign mtvec_mode_o   = mtvec_q[1:0];
  assign mepc_o         = mepc_q;

  // bypass must predict what the write path from csr_access stores
  a_mie_bypass: assert property (@(posedge clk) disable iff (!rst_n)
    1'b1 |=> (mie_q == $past(mie_bypass_o)));

  a_save_mret_excl: assert property (@(posedge clk) disable iff (!rst_n)
    !(csr_save_cause_i && csr_restore_mret_i));

  a_save_sel_onehot: assert property (@(posedge clk) disable iff (!rst_n)
    csr_save_cause_i |-> $onehot({csr_save_if_i, csr_save_id_i, csr_save_ex_i}));

endmodule

//--- csr_access.sv
/*
 * CSR access logic
 * merges per-block read data, applies write/set/clear
 * and produces the shared write data and write strobe
 */
`timescale 1ns/1ps
`include "csr_defines.svh"

module csr_access (
  input  csr_pkg::csr_op_e     csr_op_i,
  input  logic [`CSR_XLEN-1:0] csr_wdata_i,
  input  logic [`CSR_XLEN-1:0] trap_rdata_i,  // zero unless trap block owns addr
  input  logic [`CSR_XLEN-1:0] cnt_rdata_i,   // zero unless counter block owns addr
  output logic [`CSR_XLEN-1:0] csr_rdata_o,
  output logic [`CSR_XLEN-1:0] wr_data_o,
  output logic                 wr_en_o
);

  // blocks decode disjoint address sets, so OR is the mux
  assign csr_rdata_o = trap_rdata_i | cnt_rdata_i;

  //////////////////////////////////////////////////////////////////////
  // read-modify-write
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    wr_data_o = csr_wdata_i;
    wr_en_o   = 1'b1;
    case (csr_op_i)
      csr_pkg::CSR_OP_WRITE: wr_data_o = csr_wdata_i;
      csr_pkg::CSR_OP_SET:   wr_data_o = csr_wdata_i | csr_rdata_o;
      csr_pkg::CSR_OP_CLEAR: wr_data_o = ~csr_wdata_i & csr_rdata_o;
      default: begin
        wr_data_o = csr_wdata_i;  // read only
        wr_en_o   = 1'b0;
      end
    endcase
  end

  // address decoders in the two blocks must never overlap
  always_comb begin
    a_rdata_disjoint: assert #0 (!((|trap_rdata_i) && (|cnt_rdata_i)))
      else $error("trap and counter blocks both returned read data");
  end

endmodule

//--- csr_pkg.sv
/*
 * types shared by the CSR file
 * CSR operation encoding and machine CSR address map
 */
package csr_pkg;

  //////////////////////////////////////////////////////////////////////
  // csr operation, as decoded from funct3
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    CSR_OP_READ  = 2'b00,   // no write
    CSR_OP_WRITE = 2'b01,   // csrrw
    CSR_OP_SET   = 2'b10,   // csrrs
    CSR_OP_CLEAR = 2'b11    // csrrc
  } csr_op_e;

  //////////////////////////////////////////////////////////////////////
  // implemented machine-mode addresses
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [11:0] {
    // trap setup
    CSR_MSTATUS       = 12'h300,
    CSR_MISA          = 12'h301,   // read only
    CSR_MIE           = 12'h304,
    CSR_MTVEC         = 12'h305,
    CSR_MCOUNTINHIBIT = 12'h320,

    // trap handling
    CSR_MSCRATCH      = 12'h340,
    CSR_MEPC          = 12'h341,
    CSR_MCAUSE        = 12'h342,
    CSR_MIP           = 12'h344,   // pending bits come from outside

    // counters, low halves
    CSR_MCYCLE        = 12'hB00,
    CSR_MINSTRET      = 12'hB02,
    // counters, high halves
    CSR_MCYCLEH       = 12'hB80,
    CSR_MINSTRETH     = 12'hB82,

    // identity
    CSR_MHARTID       = 12'hF14
  } csr_addr_e;

endpackage

//--- csr_defines.svh
/*
 * shared constants for the machine-mode CSR file
 * widths, mstatus/mtvec/mcause field positions, reset values,
 * implemented interrupt mask and misa identity
 */
`ifndef CSR_DEFINES_SVH
`define CSR_DEFINES_SVH

`define CSR_XLEN             32             // data width
`define CSR_CNT_WIDTH        64             // mcycle / minstret width

// MSI, MTI, MEI plus fast irqs 31:16
`define CSR_IRQ_MASK         32'hFFFF_0888
// MXL=1 (RV32), I, C and M
`define CSR_MISA_VALUE       32'h4000_1104

`define CSR_MSTATUS_MIE_BIT  3
`define CSR_MSTATUS_MPIE_BIT 7
`define CSR_MSTATUS_RESET    32'h0000_1800  // MPP = machine mode

`define CSR_MTVEC_BASE_LSB   8              // base occupies 31:8
`define CSR_MTVEC_RESET      32'h0000_0001  // vectored, base 0
`define CSR_MCAUSE_CODE_W    5              // exception code bits

`endif
